//--- Makefile
VERILATOR := verilator
TOP       := execute_tb
FILELIST  := vlog.f
OBJDIR    := obj_dir
FLAGS     := --binary --timing --assert
LINTFLAGS := --lint-only --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR)

//--- common/ex_alu_if.sv
// combinational levels only, valid for the current cycle; no handshake
`timescale 1ns/1ps
`default_nettype none

interface ex_alu_if;

	logic [mips_pkg::DATA_W-1:0]  op_a;
	logic [mips_pkg::DATA_W-1:0]  op_b;
	logic [mips_pkg::DATA_W-1:0]  store_data;
	mips_pkg::alu_ctrl_e          alu_ctrl;
	logic [mips_pkg::SHAMT_W-1:0] shamt;

	// operand side, after forwarding and source muxes
	modport opsel (output op_a, output op_b, output store_data);

	// decode side
	modport dec (output alu_ctrl, output shamt);

	modport alu (input op_a, input op_b, input alu_ctrl, input shamt);

	// EX/MEM register takes the store data
	modport stage (input store_data);

endinterface

`default_nettype wire

//--- common/mips_pkg.sv
// MIPS32 integer subset only; no multiply/divide, no trap-on-overflow codes
`default_nettype none

package mips_pkg;

	// ==============================
	// datapath widths
	// ==============================
	localparam int DATA_W     = 32;
	localparam int REG_ADDR_W = 5;
	localparam int OP_W       = 6;
	localparam int FUNCT_W    = 6;
	localparam int SHAMT_W    = 5;

	// ==============================
	// opcodes
	// ==============================
	localparam logic [OP_W-1:0] OP_RTYPE = 6'h00;
	localparam logic [OP_W-1:0] OP_JAL   = 6'h03;
	localparam logic [OP_W-1:0] OP_ADDI  = 6'h08;
	localparam logic [OP_W-1:0] OP_ADDIU = 6'h09;
	localparam logic [OP_W-1:0] OP_SLTI  = 6'h0a;
	localparam logic [OP_W-1:0] OP_SLTIU = 6'h0b;
	localparam logic [OP_W-1:0] OP_ANDI  = 6'h0c;
	localparam logic [OP_W-1:0] OP_ORI   = 6'h0d;
	localparam logic [OP_W-1:0] OP_XORI  = 6'h0e;
	localparam logic [OP_W-1:0] OP_LUI   = 6'h0f;
	localparam logic [OP_W-1:0] OP_LW    = 6'h23;
	localparam logic [OP_W-1:0] OP_SW    = 6'h2b;

	// r-type function field
	localparam logic [FUNCT_W-1:0] FN_SLL  = 6'h00;
	localparam logic [FUNCT_W-1:0] FN_SRL  = 6'h02;
	localparam logic [FUNCT_W-1:0] FN_SRA  = 6'h03;
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'h20;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'h21;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'h22;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'h23;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'h24;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'h25;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'h26;
	localparam logic [FUNCT_W-1:0] FN_NOR  = 6'h27;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'h2a;
	localparam logic [FUNCT_W-1:0] FN_SLTU = 6'h2b;

	// alu operation select
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT,
		ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_A
	} alu_ctrl_e;

	// forwarding source per operand
	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_MEM = 2'd1,
		FWD_WB  = 2'd2
	} fwd_sel_e;

endpackage

`default_nettype wire

//--- execute/ex_alu.sv
// no overflow detection; add and sub wrap silently, shifts act on operand B
`timescale 1ns/1ps
`default_nettype none

module ex_alu (
	ex_alu_if.alu                             alu_bus,
	output logic [mips_pkg::DATA_W-1:0]       o_result
);

	logic [mips_pkg::DATA_W-1:0]  a;
	logic [mips_pkg::DATA_W-1:0]  b;
	logic [mips_pkg::SHAMT_W-1:0] sh;
	logic                         lt_signed;
	logic                         lt_unsigned;

	assign a  = alu_bus.op_a;
	assign b  = alu_bus.op_b;
	assign sh = alu_bus.shamt;

	// ==============================
	// compares
	// ==============================
	assign lt_signed   = $signed(a) < $signed(b);
	assign lt_unsigned = a < b;

	// ==============================
	// result select
	// ==============================
	always_comb begin
		case (alu_bus.alu_ctrl)
			mips_pkg::ALU_ADD:
				o_result = a + b;
			mips_pkg::ALU_SUB:
				o_result = a - b;
			mips_pkg::ALU_AND:
				o_result = a & b;
			mips_pkg::ALU_OR:
				o_result = a | b;
			mips_pkg::ALU_XOR:
				o_result = a ^ b;
			mips_pkg::ALU_NOR:
				o_result = ~(a | b);
			// set-less-than gives 0 or 1
			mips_pkg::ALU_SLT:
				o_result = {{(mips_pkg::DATA_W-1){1'b0}}, lt_signed};
			mips_pkg::ALU_SLTU:
				o_result = {{(mips_pkg::DATA_W-1){1'b0}}, lt_unsigned};
			mips_pkg::ALU_SLL:
				o_result = b << sh;
			mips_pkg::ALU_SRL:
				o_result = b >> sh;
			// arithmetic shift keeps the sign
			mips_pkg::ALU_SRA:
				o_result = $unsigned($signed(b) >>> sh);
			mips_pkg::ALU_LUI:
				o_result = {b[15:0], 16'h0000};
			// link address for jal
			mips_pkg::ALU_PASS_A:
				o_result = a;
			default:
				o_result = a + b;
		endcase
	end

endmodule

`default_nettype wire

//--- execute/ex_alu_decode.sv
// funct and shamt are taken from the extended immediate; unknown codes decode to ADD
`timescale 1ns/1ps
`default_nettype none

module ex_alu_decode (
	input  wire logic [mips_pkg::OP_W-1:0]   i_aluop,
	input  wire logic [mips_pkg::DATA_W-1:0] i_imm,
	ex_alu_if.dec                            alu_bus
);

	logic [mips_pkg::FUNCT_W-1:0] funct;

	// low bits of the instruction survive sign extension
	assign funct         = i_imm[5:0];
	assign alu_bus.shamt = i_imm[10:6];

	// ==============================
	// r-type function decode
	// ==============================
	function automatic mips_pkg::alu_ctrl_e decode_funct(
		input logic [mips_pkg::FUNCT_W-1:0] fn
	);
		case (fn)
			mips_pkg::FN_SLL:  return mips_pkg::ALU_SLL;
			mips_pkg::FN_SRL:  return mips_pkg::ALU_SRL;
			mips_pkg::FN_SRA:  return mips_pkg::ALU_SRA;
			mips_pkg::FN_SUB,
			mips_pkg::FN_SUBU: return mips_pkg::ALU_SUB;
			mips_pkg::FN_AND:  return mips_pkg::ALU_AND;
			mips_pkg::FN_OR:   return mips_pkg::ALU_OR;
			mips_pkg::FN_XOR:  return mips_pkg::ALU_XOR;
			mips_pkg::FN_NOR:  return mips_pkg::ALU_NOR;
			mips_pkg::FN_SLT:  return mips_pkg::ALU_SLT;
			mips_pkg::FN_SLTU: return mips_pkg::ALU_SLTU;
			// add, addu and anything unrecognised
			default:           return mips_pkg::ALU_ADD;
		endcase
	endfunction

	// opcode decode
	always_comb begin
		case (i_aluop)
			mips_pkg::OP_RTYPE: alu_bus.alu_ctrl = decode_funct(funct);
			mips_pkg::OP_SLTI:  alu_bus.alu_ctrl = mips_pkg::ALU_SLT;
			mips_pkg::OP_SLTIU: alu_bus.alu_ctrl = mips_pkg::ALU_SLTU;
			mips_pkg::OP_ANDI:  alu_bus.alu_ctrl = mips_pkg::ALU_AND;
			mips_pkg::OP_ORI:   alu_bus.alu_ctrl = mips_pkg::ALU_OR;
			mips_pkg::OP_XORI:  alu_bus.alu_ctrl = mips_pkg::ALU_XOR;
			mips_pkg::OP_LUI:   alu_bus.alu_ctrl = mips_pkg::ALU_LUI;
			mips_pkg::OP_JAL:   alu_bus.alu_ctrl = mips_pkg::ALU_PASS_A;
			// addi, addiu, lw, sw compute a sum or an address
			default:            alu_bus.alu_ctrl = mips_pkg::ALU_ADD;
		endcase
	end

endmodule

`default_nettype wire

//--- execute/ex_operand_select.sv
// forwards from MEM and WB only, MEM wins; register 0 is never forwarded
`timescale 1ns/1ps
`default_nettype none

module ex_operand_select (
	input  wire logic [mips_pkg::DATA_W-1:0]     i_rs_data,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_rt_data,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_imm,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_pc4,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rs_addr,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_rt_addr,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_mem_fwd_data,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_wb_fwd_data,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_mem_dst,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_wb_dst,
	input  wire logic                            i_mem_regwrite,
	input  wire logic                            i_wb_regwrite,
	input  wire logic                            i_alusrc,
	input  wire logic                            i_alupc4,
	ex_alu_if.opsel                              alu_bus
);

	// ==============================
	// forwarding select
	// ==============================
	function automatic mips_pkg::fwd_sel_e pick_source(
		input logic [mips_pkg::REG_ADDR_W-1:0] src,
		input logic [mips_pkg::REG_ADDR_W-1:0] mem_dst,
		input logic [mips_pkg::REG_ADDR_W-1:0] wb_dst,
		input logic                            mem_we,
		input logic                            wb_we
	);
		mips_pkg::fwd_sel_e sel;
		sel = mips_pkg::FWD_REG;
		if (wb_we && (wb_dst != '0) && (wb_dst == src))
			sel = mips_pkg::FWD_WB;
		// mem stage holds the younger value
		if (mem_we && (mem_dst != '0) && (mem_dst == src))
			sel = mips_pkg::FWD_MEM;
		return sel;
	endfunction

	mips_pkg::fwd_sel_e          fwd_a;
	mips_pkg::fwd_sel_e          fwd_b;
	logic [mips_pkg::DATA_W-1:0] rs_fwd;
	logic [mips_pkg::DATA_W-1:0] rt_fwd;

	assign fwd_a = pick_source(i_rs_addr, i_mem_dst, i_wb_dst, i_mem_regwrite, i_wb_regwrite);
	assign fwd_b = pick_source(i_rt_addr, i_mem_dst, i_wb_dst, i_mem_regwrite, i_wb_regwrite);

	// ==============================
	// forwarded operands
	// ==============================
	always_comb begin
		case (fwd_a)
			mips_pkg::FWD_MEM: rs_fwd = i_mem_fwd_data;
			mips_pkg::FWD_WB:  rs_fwd = i_wb_fwd_data;
			default:           rs_fwd = i_rs_data;
		endcase
		case (fwd_b)
			mips_pkg::FWD_MEM: rt_fwd = i_mem_fwd_data;
			mips_pkg::FWD_WB:  rt_fwd = i_wb_fwd_data;
			default:           rt_fwd = i_rt_data;
		endcase
	end

	// pc+4 feeds A for the link path
	assign alu_bus.op_a       = i_alupc4 ? i_pc4 : rs_fwd;
	assign alu_bus.op_b       = i_alusrc ? i_imm : rt_fwd;
	assign alu_bus.store_data = rt_fwd;

endmodule

`default_nettype wire

//--- execute/execute.sv
// one-cycle EX/MEM register, no stall or flush; immediate arrives already extended
`timescale 1ns/1ps
`default_nettype none

module execute (
	input  wire logic                            i_clk,
	input  wire logic                            i_nrst,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_data_pc4,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_data_rs,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_data_rt,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_data_immext,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_rs,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_rt,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_rd,
	// forwarding from later stages
	input  wire logic [mips_pkg::DATA_W-1:0]     i_data_mem_fwd,
	input  wire logic [mips_pkg::DATA_W-1:0]     i_data_wb_fwd,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_mem_dst,
	input  wire logic [mips_pkg::REG_ADDR_W-1:0] i_addr_wb_dst,
	input  wire logic                            i_con_mem_regwrite,
	input  wire logic                            i_con_wb_regwrite,
	// stage and pass-through controls
	input  wire logic [mips_pkg::OP_W-1:0]       i_con_aluop,
	input  wire logic                            i_con_alusrc,
	input  wire logic                            i_con_regdst,
	input  wire logic                            i_con_alupc4,
	input  wire logic                            i_con_Mmemread,
	input  wire logic                            i_con_Mmemwrite,
	input  wire logic [1:0]                      i_con_Wloadmux,
	input  wire logic                            i_con_Wmemtoreg,
	input  wire logic                            i_con_Wregwrite,

	output logic [mips_pkg::DATA_W-1:0]          o_data_alures,
	output logic [mips_pkg::DATA_W-1:0]          o_data_rt,
	output logic [mips_pkg::REG_ADDR_W-1:0]      o_addr_regdst,
	output logic                                 o_con_Mmemread,
	output logic                                 o_con_Mmemwrite,
	output logic [1:0]                           o_con_Wloadmux,
	output logic                                 o_con_Wmemtoreg,
	output logic                                 o_con_Wregwrite
);

	ex_alu_if alu_bus ();

	logic [mips_pkg::DATA_W-1:0]     alu_result;
	logic [mips_pkg::REG_ADDR_W-1:0] regdst;

	// ==============================
	// stage blocks
	// ==============================
	ex_operand_select u_operand_select (
		.i_rs_data      (i_data_rs),
		.i_rt_data      (i_data_rt),
		.i_imm          (i_data_immext),
		.i_pc4          (i_data_pc4),
		.i_rs_addr      (i_addr_rs),
		.i_rt_addr      (i_addr_rt),
		.i_mem_fwd_data (i_data_mem_fwd),
		.i_wb_fwd_data  (i_data_wb_fwd),
		.i_mem_dst      (i_addr_mem_dst),
		.i_wb_dst       (i_addr_wb_dst),
		.i_mem_regwrite (i_con_mem_regwrite),
		.i_wb_regwrite  (i_con_wb_regwrite),
		.i_alusrc       (i_con_alusrc),
		.i_alupc4       (i_con_alupc4),
		.alu_bus        (alu_bus.opsel)
	);

	ex_alu_decode u_alu_decode (
		.i_aluop (i_con_aluop),
		.i_imm   (i_data_immext),
		.alu_bus (alu_bus.dec)
	);

	ex_alu u_alu (
		.alu_bus  (alu_bus.alu),
		.o_result (alu_result)
	);

	// rd for r-type, rt for immediate forms
	assign regdst = i_con_regdst ? i_addr_rd : i_addr_rt;

	// ==============================
	// EX/MEM register
	// ==============================
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			o_data_alures   <= '0;
			o_data_rt       <= '0;
			o_addr_regdst   <= '0;
			o_con_Mmemread  <= 1'b0;
			o_con_Mmemwrite <= 1'b0;
			o_con_Wloadmux  <= 2'b00;
			o_con_Wmemtoreg <= 1'b0;
			o_con_Wregwrite <= 1'b0;
		end else begin
			o_data_alures   <= alu_result;
			o_data_rt       <= alu_bus.store_data;
			o_addr_regdst   <= regdst;
			o_con_Mmemread  <= i_con_Mmemread;
			o_con_Mmemwrite <= i_con_Mmemwrite;
			o_con_Wloadmux  <= i_con_Wloadmux;
			o_con_Wmemtoreg <= i_con_Wmemtoreg;
			o_con_Wregwrite <= i_con_Wregwrite;
		end
	end

endmodule

`default_nettype wire

//--- verif/execute_props.sv
// sampled on the rising clock; assumes stimulus never sets memread and memwrite together
`timescale 1ns/1ps
`default_nettype none

module execute_props (
	input wire logic       i_clk,
	input wire logic       i_nrst,
	input wire logic       i_con_Mmemread,
	input wire logic       i_con_Mmemwrite,
	input wire logic [1:0] i_con_Wloadmux,
	input wire logic       i_con_Wmemtoreg,
	input wire logic       i_con_Wregwrite,
	input wire logic       o_con_Mmemread,
	input wire logic       o_con_Mmemwrite,
	input wire logic [1:0] o_con_Wloadmux,
	input wire logic       o_con_Wmemtoreg,
	input wire logic       o_con_Wregwrite
);

	// ==============================
	// control outputs
	// ==============================
	reset_clears: assert property (@(posedge i_clk)
		!i_nrst |-> !(o_con_Mmemread || o_con_Mmemwrite || o_con_Wmemtoreg || o_con_Wregwrite))
		else $error("control outputs not clear while reset is low");

	// one cycle from input to output
	pass_through: assert property (@(posedge i_clk) disable iff (!i_nrst)
		$past(i_nrst) |-> {o_con_Mmemread, o_con_Mmemwrite, o_con_Wloadmux, o_con_Wmemtoreg,
			o_con_Wregwrite} == $past({i_con_Mmemread, i_con_Mmemwrite, i_con_Wloadmux,
			i_con_Wmemtoreg, i_con_Wregwrite}))
		else $error("control outputs differ from last cycle's inputs");

	mem_exclusive: assert property (@(posedge i_clk) disable iff (!i_nrst)
		!(o_con_Mmemread && o_con_Mmemwrite))
		else $error("memread and memwrite high together");

endmodule

bind execute execute_props u_props (.*);

`default_nettype wire

//--- verif/execute_tb.sv
// directed tests on random operands (seed 32'hd8fb); expected values come from the stage rules
`timescale 1ns/1ps
`default_nettype none

module execute_tb;

	localparam int CLK_NS    = 4;
	localparam int NUM_TESTS = 6;

	logic                            i_clk;
	logic                            i_nrst;
	logic [mips_pkg::DATA_W-1:0]     i_data_pc4;
	logic [mips_pkg::DATA_W-1:0]     i_data_rs;
	logic [mips_pkg::DATA_W-1:0]     i_data_rt;
	logic [mips_pkg::DATA_W-1:0]     i_data_immext;
	logic [mips_pkg::REG_ADDR_W-1:0] i_addr_rs;
	logic [mips_pkg::REG_ADDR_W-1:0] i_addr_rt;
	logic [mips_pkg::REG_ADDR_W-1:0] i_addr_rd;
	logic [mips_pkg::DATA_W-1:0]     i_data_mem_fwd;
	logic [mips_pkg::DATA_W-1:0]     i_data_wb_fwd;
	logic [mips_pkg::REG_ADDR_W-1:0] i_addr_mem_dst;
	logic [mips_pkg::REG_ADDR_W-1:0] i_addr_wb_dst;
	logic                            i_con_mem_regwrite;
	logic                            i_con_wb_regwrite;
	logic [mips_pkg::OP_W-1:0]       i_con_aluop;
	logic                            i_con_alusrc;
	logic                            i_con_regdst;
	logic                            i_con_alupc4;
	logic                            i_con_Mmemread;
	logic                            i_con_Mmemwrite;
	logic [1:0]                      i_con_Wloadmux;
	logic                            i_con_Wmemtoreg;
	logic                            i_con_Wregwrite;
	logic [mips_pkg::DATA_W-1:0]     o_data_alures;
	logic [mips_pkg::DATA_W-1:0]     o_data_rt;
	logic [mips_pkg::REG_ADDR_W-1:0] o_addr_regdst;
	logic                            o_con_Mmemread;
	logic                            o_con_Mmemwrite;
	logic [1:0]                      o_con_Wloadmux;
	logic                            o_con_Wmemtoreg;
	logic                            o_con_Wregwrite;

	// last checked outputs, held between edges
	logic [31:0]                     held_res;
	logic [31:0]                     held_rt;
	logic [4:0]                      held_dst;
	logic [5:0]                      held_ctl;

	execute execute_i (.*);

	initial i_clk = 1'b0;
	always #(CLK_NS / 2) i_clk = ~i_clk;

	// watchdog
	initial begin
		#(200 * NUM_TESTS * CLK_NS);
		$display("STATUS: FAIL");
		$fatal(1, "timeout, the tests did not finish within %0d cycles", 200 * NUM_TESTS);
	end

	// ==============================
	// reference model
	// ==============================
	function automatic logic [31:0] fwd_value(input logic [4:0] src, input logic [31:0] reg_val);
		if (i_con_mem_regwrite && (i_addr_mem_dst != 5'd0) && (i_addr_mem_dst == src))
			return i_data_mem_fwd;
		if (i_con_wb_regwrite && (i_addr_wb_dst != 5'd0) && (i_addr_wb_dst == src))
			return i_data_wb_fwd;
		return reg_val;
	endfunction

	function automatic logic [31:0] model_result();
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  sh;
		a  = i_con_alupc4 ? i_data_pc4 : fwd_value(i_addr_rs, i_data_rs);
		b  = i_con_alusrc ? i_data_immext : fwd_value(i_addr_rt, i_data_rt);
		sh = i_data_immext[10:6];
		case (i_con_aluop)
			mips_pkg::OP_RTYPE:
				case (i_data_immext[5:0])
					mips_pkg::FN_SLL:  return b << sh;
					mips_pkg::FN_SRL:  return b >> sh;
					mips_pkg::FN_SRA:  return $signed(b) >>> sh;
					mips_pkg::FN_SUB:  return a - b;
					mips_pkg::FN_SUBU: return a - b;
					mips_pkg::FN_AND:  return a & b;
					mips_pkg::FN_OR:   return a | b;
					mips_pkg::FN_XOR:  return a ^ b;
					mips_pkg::FN_NOR:  return ~(a | b);
					mips_pkg::FN_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
					mips_pkg::FN_SLTU: return (a < b) ? 32'd1 : 32'd0;
					default:           return a + b;
				endcase
			mips_pkg::OP_SLTI:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			mips_pkg::OP_SLTIU: return (a < b) ? 32'd1 : 32'd0;
			mips_pkg::OP_ANDI:  return a & b;
			mips_pkg::OP_ORI:   return a | b;
			mips_pkg::OP_XORI:  return a ^ b;
			mips_pkg::OP_LUI:   return {b[15:0], 16'h0000};
			mips_pkg::OP_JAL:   return a;
			default:            return a + b;
		endcase
	endfunction

	// ==============================
	// drive and check helpers
	// ==============================
	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("FAILED t=%0t %s expected %h got %h", $time, name, exp, act);
			$display("STATUS: FAIL");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	// ctl is {memread, memwrite, loadmux, memtoreg, regwrite}
	task automatic check_outputs(input logic [31:0] res, input logic [31:0] rt,
		input logic [4:0] dst, input logic [5:0] ctl);
		check_val("o_data_alures", res, o_data_alures);
		check_val("o_data_rt", rt, o_data_rt);
		check_val("o_addr_regdst", 32'(dst), 32'(o_addr_regdst));
		check_val("o_con_Mmemread", 32'(ctl[5]), 32'(o_con_Mmemread));
		check_val("o_con_Mmemwrite", 32'(ctl[4]), 32'(o_con_Mmemwrite));
		check_val("o_con_Wloadmux", 32'(ctl[3:2]), 32'(o_con_Wloadmux));
		check_val("o_con_Wmemtoreg", 32'(ctl[1]), 32'(o_con_Wmemtoreg));
		check_val("o_con_Wregwrite", 32'(ctl[0]), 32'(o_con_Wregwrite));
	endtask

	// forwarding off unless a test turns it on
	task automatic load_random_operands();
		i_data_pc4         = $urandom;
		i_data_rs          = $urandom;
		i_data_rt          = $urandom;
		i_data_mem_fwd     = $urandom;
		i_data_wb_fwd      = $urandom;
		i_addr_rs          = 5'($urandom);
		i_addr_rt          = 5'($urandom);
		i_addr_rd          = 5'($urandom);
		i_addr_mem_dst     = 5'($urandom);
		i_addr_wb_dst      = 5'($urandom);
		i_con_mem_regwrite = 1'b0;
		i_con_wb_regwrite  = 1'b0;
	endtask

	task automatic set_ctrl(input logic [5:0] op, input logic alusrc, input logic regdst,
		input logic alupc4, input logic [5:0] pass);
		i_con_aluop  = op;
		i_con_alusrc = alusrc;
		i_con_regdst = regdst;
		i_con_alupc4 = alupc4;
		{i_con_Mmemread, i_con_Mmemwrite, i_con_Wloadmux, i_con_Wmemtoreg, i_con_Wregwrite} = pass;
	endtask

	// expected values taken before the edge, checked half a ns after it
	// outputs keep the last results until that edge
	task automatic step_and_check();
		logic [31:0] exp_res;
		logic [31:0] exp_rt;
		logic [4:0]  exp_dst;
		logic [5:0]  exp_ctl;
		exp_res = model_result();
		exp_rt  = fwd_value(i_addr_rt, i_data_rt);
		exp_dst = i_con_regdst ? i_addr_rd : i_addr_rt;
		exp_ctl = {i_con_Mmemread, i_con_Mmemwrite, i_con_Wloadmux, i_con_Wmemtoreg, i_con_Wregwrite};
		#0.5;
		check_outputs(held_res, held_rt, held_dst, held_ctl);
		@(posedge i_clk);
		#0.5;
		check_outputs(exp_res, exp_rt, exp_dst, exp_ctl);
		held_res = exp_res;
		held_rt  = exp_rt;
		held_dst = exp_dst;
		held_ctl = exp_ctl;
	endtask

	// ==============================
	// directed tests
	// ==============================
	task automatic reset_values();
		held_res = '0;
		held_rt  = '0;
		held_dst = '0;
		held_ctl = '0;
		check_outputs(held_res, held_rt, held_dst, held_ctl);
	endtask

	// all 64 function codes, unknown ones decode as add
	task automatic rtype_ops();
		for (int f = 0; f < 64; f++) begin
			load_random_operands();
			i_data_immext = {16'h0000, i_addr_rd, 5'($urandom), 6'(f)};
			set_ctrl(mips_pkg::OP_RTYPE, 1'b0, 1'b1, 1'b0, 6'b000001);
			step_and_check();
		end
		// sign bit splits slt from sltu
		load_random_operands();
		i_data_rs     = 32'h8000_0000;
		i_data_rt     = 32'h0000_0001;
		i_data_immext = {26'h0, mips_pkg::FN_SLT};
		step_and_check();
		i_data_immext = {26'h0, mips_pkg::FN_SLTU};
		step_and_check();
	endtask

	task automatic immediate_ops();
		logic [5:0]  ops [8];
		logic [5:0]  pass;
		logic [15:0] half;
		ops = '{mips_pkg::OP_ADDI, mips_pkg::OP_SLTI, mips_pkg::OP_ANDI, mips_pkg::OP_ORI,
			mips_pkg::OP_XORI, mips_pkg::OP_LUI, mips_pkg::OP_LW, mips_pkg::OP_SW};
		foreach (ops[k]) begin
			load_random_operands();
			half          = 16'($urandom);
			i_data_immext = {{16{half[15]}}, half};
			pass          = 6'b000001;
			if (ops[k] == mips_pkg::OP_LW)
				pass = {2'b10, 2'($urandom), 2'b11};
			if (ops[k] == mips_pkg::OP_SW)
				pass = 6'b010000;
			set_ctrl(ops[k], 1'b1, 1'b0, 1'b0, pass);
			step_and_check();
		end
	endtask

	task automatic forwarding_paths();
		for (int c = 0; c < 5; c++) begin
			load_random_operands();
			i_addr_rs          = 5'd7;
			i_addr_rt          = 5'd12;
			i_con_mem_regwrite = 1'b1;
			i_con_wb_regwrite  = 1'b1;
			i_data_immext      = {16'h0000, i_addr_rd, 5'd0, mips_pkg::FN_ADD};
			set_ctrl(mips_pkg::OP_RTYPE, 1'b0, 1'b1, 1'b0, 6'b000001);
			case (c)
				0: begin
					i_addr_mem_dst = i_addr_rs;
					i_addr_wb_dst  = i_addr_rt;
				end
				1: begin
					i_addr_mem_dst = i_addr_rt;
					i_addr_wb_dst  = i_addr_rs;
				end
				// both stages hit, mem must win
				2: begin
					i_addr_rt      = i_addr_rs;
					i_addr_mem_dst = i_addr_rs;
					i_addr_wb_dst  = i_addr_rs;
				end
				3: begin
					i_addr_rs      = 5'd0;
					i_addr_rt      = 5'd0;
					i_addr_mem_dst = 5'd0;
					i_addr_wb_dst  = 5'd0;
				end
				// store data picks up the forwarded rt
				default: begin
					i_addr_mem_dst = i_addr_rt;
					i_addr_wb_dst  = 5'd30;
					i_data_immext  = 32'($urandom % 256);
					set_ctrl(mips_pkg::OP_SW, 1'b1, 1'b0, 1'b0, 6'b010000);
				end
			endcase
			step_and_check();
		end
	endtask

	task automatic link_path();
		repeat (2) begin
			load_random_operands();
			i_con_mem_regwrite = 1'b1;
			i_addr_mem_dst     = i_addr_rs;
			i_addr_rd          = 5'd31;
			i_data_immext      = $urandom;
			set_ctrl(mips_pkg::OP_JAL, 1'b0, 1'b1, 1'b1, 6'b000001);
			step_and_check();
		end
	endtask

	task automatic back_to_back();
		logic [5:0] ops [6];
		logic [5:0] pass;
		ops = '{mips_pkg::OP_RTYPE, mips_pkg::OP_ADDI, mips_pkg::OP_LW, mips_pkg::OP_SW,
			mips_pkg::OP_LUI, mips_pkg::OP_ORI};
		repeat (4) begin
			foreach (ops[k]) begin
				load_random_operands();
				i_con_mem_regwrite = 1'($urandom);
				i_con_wb_regwrite  = 1'($urandom);
				i_data_immext      = $urandom;
				pass               = (ops[k] == mips_pkg::OP_SW) ? 6'b010000 : 6'b000001;
				if (ops[k] == mips_pkg::OP_LW)
					pass = 6'b100011;
				set_ctrl(ops[k], ops[k] != mips_pkg::OP_RTYPE, ops[k] == mips_pkg::OP_RTYPE,
					1'b0, pass);
				step_and_check();
			end
		end
	endtask

	initial begin
		void'($urandom(32'hd8fb));
		i_nrst = 1'b0;
		load_random_operands();
		i_data_immext = '0;
		set_ctrl(mips_pkg::OP_RTYPE, 1'b0, 1'b0, 1'b0, 6'b000000);
		repeat (4) @(posedge i_clk);
		#0.5;
		i_nrst = 1'b1;
		reset_values();
		rtype_ops();
		immediate_ops();
		forwarding_paths();
		link_path();
		back_to_back();
		$display("STATUS: PASS");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
common/mips_pkg.sv
common/ex_alu_if.sv
execute/ex_operand_select.sv
execute/ex_alu_decode.sv
execute/ex_alu.sv
execute/execute.sv
verif/execute_props.sv
verif/execute_tb.sv
